// File: sys1_main.f
logic/sys1_bus_pkg.sv
logic/sys1_map_pkg.sv
logic/sys1_bus_decode.sv
logic/sys1_iport.sv
logic/sys1_prog_rom.sv
logic/sys1_opdecrypt.sv
logic/sys1_io_latch.sv
logic/sys1_work_ram.sv
logic/sys1_main.sv
test/sys1_main_assertions.sv
test/sys1_main_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sys1_main_tb -f sys1_main.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vsys1_main_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation returned status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

// File: test/sys1_main_tb.sv
// Plays the CPU one bus cycle per CLK48M; the whole ROM image is downloaded before any ROM read
`timescale 1ns/1ns
`default_nettype none

module sys1_main_tb import sys1_bus_pkg::*;;

	localparam int ROM_SIZE  = 49152;
	localparam int N_RD      = 256;
	localparam int N_RAM     = 64;
	localparam int TOTAL_CYC = ROM_SIZE + 4 * N_RD + 3 * N_RAM + 200;
	localparam logic [7:0] PORTS [6] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h0D, 8'h10};

	logic       CLK48M;
	logic       RESET;
	cpu_bus_t   cpu_bus;
	rom_dl_t    rom_dl;
	logic [7:0] cpu_din;
	logic [7:0] inp0, inp1, inp2, dsw0, dsw1;
	logic       vid_cs;
	logic [7:0] vid_do;
	logic       snd_req;
	logic [7:0] snd_no;
	logic [7:0] vid_mode;

	// Mirrors of the board state
	logic [7:0]  rom_img [0:ROM_SIZE-1];
	logic [7:0]  key_img [0:15];
	logic [7:0]  ram_img [0:4095];
	logic [7:0]  vidm_exp;
	logic [11:0] ram_addr [0:N_RAM-1];

	// Read issued this cycle, and the one whose data is on cpu_din
	logic       iss_v;
	logic [7:0] iss_exp;
	logic       chk_v;
	logic [7:0] chk_exp;

	int n_chk = 0;
	int n_err = 0;
	int chk0 = 0;
	int err0 = 0;
	int pulses = 0;

	sys1_main dut0 (.*);

	initial begin
		CLK48M = 1'b0;
		forever #20 CLK48M = ~CLK48M;
	end

	task automatic compare_val(input string name, input logic [7:0] exp, input logic [7:0] act);
		n_chk++;
		if (act !== exp) begin
			n_err++;
			$display("** Error at %0t ns: %s expected %02h, got %02h", $time, name, exp, act);
		end
	endtask

	// Expected read byte for the current mirrors and board inputs
	function automatic logic [7:0] ref_data(input logic [15:0] a, input logic m1, input logic iorq);
		if (vid_cs) return vid_do;
		if (iorq) begin
			if (a[7:0] == 8'h15 || a[7:0] == 8'h19) return vidm_exp;
			case (a[4:2])
				3'd0: return inp0;
				3'd1: return inp1;
				3'd2: return inp2;
				3'd3: return a[0] ? dsw1 : dsw0;
				3'd4: return dsw1;
				default: return 8'hFF;
			endcase
		end
		if (!a[15]) return rom_img[a] ^ key_img[{m1, a[12], a[8], a[4]}];
		if (a[15:14] == 2'b10) return rom_img[a];
		if (a[15:12] == 4'hC) return ram_img[a[11:0]];
		return 8'hFF;
	endfunction

	task automatic bus_idle();
		@(posedge CLK48M);
		#5;
		cpu_bus = '0;
		iss_v = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, input logic m1, input logic iorq);
		@(posedge CLK48M);
		#5;
		cpu_bus = '0;
		cpu_bus.addr.mem = a;
		cpu_bus.m1 = m1;
		cpu_bus.mreq = !iorq;
		cpu_bus.iorq = iorq;
		cpu_bus.rd = 1'b1;
		iss_v = 1'b1;
		iss_exp = ref_data(a, m1, iorq);
	endtask

	// One write cycle, then an idle cycle
	task automatic bus_write(input logic [15:0] a, input logic iorq, input logic [7:0] d);
		@(posedge CLK48M);
		#5;
		cpu_bus = '0;
		cpu_bus.addr.mem = a;
		cpu_bus.mreq = !iorq;
		cpu_bus.iorq = iorq;
		cpu_bus.wr = 1'b1;
		cpu_bus.dout = d;
		iss_v = 1'b0;
		bus_idle();
	endtask

	task automatic dl_write(input logic [24:0] a, input logic [7:0] d);
		@(posedge CLK48M);
		#5;
		rom_dl.addr = a;
		rom_dl.data = d;
		rom_dl.en = 1'b1;
	endtask

	task automatic finish_test(input string name);
		bus_idle();
		bus_idle();
		$display("%s: %0d checks, %0d errors", name, n_chk - chk0, n_err - err0);
		chk0 = n_chk;
		err0 = n_err;
	endtask

	always @(posedge CLK48M) begin
		chk_v <= iss_v;
		chk_exp <= iss_exp;
	end

	always @(negedge CLK48M) begin
		if (chk_v) compare_val("cpu_din", chk_exp, cpu_din);
		if (snd_req) pulses++;
	end

	initial begin
		#(TOTAL_CYC * 40 + 4000);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [7:0]  d;
		logic [15:0] a;
		void'($urandom(13348));
		RESET = 1'b1;
		cpu_bus = '0;
		rom_dl = '0;
		{inp0, inp1, inp2, dsw0, dsw1} = '0;
		vid_cs = 1'b0;
		vid_do = 8'h00;
		iss_v = 1'b0;
		iss_exp = 8'hFF;
		vidm_exp = 8'h00;
		repeat (4) @(posedge CLK48M);
		#5;
		RESET = 1'b0;

		@(negedge CLK48M);
		compare_val("snd_req", 8'h00, {7'd0, snd_req});
		compare_val("vid_mode", 8'h00, vid_mode);
		compare_val("snd_no", 8'h00, snd_no);
		bus_read(16'hD000, 1'b0, 1'b0);
		finish_test("reset");

		for (int i = 0; i < ROM_SIZE; i++) begin
			d = 8'($urandom());
			rom_img[i] = d;
			dl_write(25'(i), d);
		end
		for (int i = 0; i < 16; i++) begin
			key_img[i] = 8'h00;
			dl_write(25'h0C000 + 25'(i), 8'h00);
		end
		bus_idle();
		rom_dl = '0;
		for (int i = 0; i < N_RD; i++) begin
			bus_read({2'b10, 14'($urandom())}, 1'b0, 1'b0);
			bus_read({1'b0, 15'($urandom())}, 1'($urandom()), 1'b0);
		end
		finish_test("rom download");

		for (int i = 0; i < 16; i++) begin
			d = 8'($urandom());
			key_img[i] = d;
			dl_write(25'h0C000 + 25'(i), d);
		end
		bus_idle();
		rom_dl = '0;
		// Back to back, m1 alternating
		for (int i = 0; i < 2 * N_RD; i++) begin
			bus_read({1'b0, 15'($urandom())}, 1'(i), 1'b0);
		end
		finish_test("decryption");

		for (int i = 0; i < N_RAM; i++) begin
			ram_addr[i] = 12'($urandom());
			d = 8'($urandom());
			ram_img[ram_addr[i]] = d;
			bus_write({4'hC, ram_addr[i]}, 1'b0, d);
		end
		for (int i = 0; i < N_RAM; i++) begin
			bus_read({4'hC, ram_addr[i]}, 1'b0, 1'b0);
		end
		finish_test("work ram");

		{inp0, inp1, inp2, dsw0, dsw1} = 40'({$urandom(), $urandom()});
		for (int k = 0; k < 6; k++) begin
			bus_read({8'h00, PORTS[k]}, 1'b0, 1'b1);
		end
		bus_idle();
		vid_cs = 1'b1;
		vid_do = 8'($urandom());
		for (int k = 0; k < 6; k++) begin
			bus_read({8'h00, PORTS[k]}, 1'b0, 1'b1);
		end
		bus_idle();
		vid_cs = 1'b0;
		finish_test("io ports");

		for (int k = 0; k < 2; k++) begin
			a = (k == 0) ? 16'h0015 : 16'h0019;
			d = 8'($urandom());
			vidm_exp = d;
			bus_write(a, 1'b1, d);
			compare_val("vid_mode", d, vid_mode);
			bus_read(16'h0015, 1'b0, 1'b1);
			bus_read(16'h0019, 1'b0, 1'b1);
			bus_idle();
		end
		pulses = 0;
		for (int k = 0; k < 4; k++) begin
			a = k[0] ? 16'h0018 : 16'h0014;
			d = 8'($urandom());
			bus_write(a, 1'b1, d);
			compare_val("snd_no", d, snd_no);
		end
		bus_idle();
		compare_val("snd_req pulses", 8'd4, 8'(pulses));
		finish_test("latches");

		$display("Total: %0d checks, %0d errors", n_chk, n_err);
		if (n_err == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/sys1_main_assertions.sv
// Bound into the latch and the decoder; tied-off inputs leave the unrelated checks vacuous
`timescale 1ns/1ns
`default_nettype none

module sys1_main_assertions (
	input wire       CLK48M,
	input wire       RESET,
	input wire       snd_req,
	input wire       idle,
	input wire [7:0] cpu_din
);

	// Sound request is a single-cycle strobe
	a_snd_single: assert property (@(posedge CLK48M) disable iff (RESET) snd_req |=> !snd_req)
		else $error("snd_req high for two consecutive cycles");

	a_snd_reset: assert property (@(posedge CLK48M) RESET |-> !snd_req)
		else $error("snd_req high during reset");

	// No read source selected, so the bus floats high next cycle
	a_open_bus: assert property (@(posedge CLK48M) disable iff (RESET) idle |=> cpu_din == 8'hFF)
		else $error("cpu_din not FFh after a cycle without a read select");

endmodule

bind sys1_io_latch sys1_main_assertions u_latch_chk (
	.CLK48M(CLK48M), .RESET(RESET), .snd_req(snd_req), .idle(1'b1), .cpu_din(8'hFF)
);

bind sys1_bus_decode sys1_main_assertions u_decode_chk (
	.CLK48M(CLK48M), .RESET(RESET), .snd_req(1'b0), .cpu_din(cpu_din),
	.idle(!(cpu_bus.rd && (cs_ram || cs_rom0 || cs_rom1 || vid_cs || cs_vidm || port_dv)))
);

`default_nettype wire

// File: logic/sys1_main.sv
// Main CPU board glue without the CPU core; cpu_din follows a sampled read by one CLK48M cycle
`timescale 1ns/1ns
`default_nettype none

module sys1_main
	import sys1_bus_pkg::*;
(
	input  wire        CLK48M,
	input  wire        RESET,
	input  cpu_bus_t   cpu_bus,
	output logic [7:0] cpu_din,
	input  rom_dl_t    rom_dl,
	input  wire  [7:0] inp0,
	input  wire  [7:0] inp1,
	input  wire  [7:0] inp2,
	input  wire  [7:0] dsw0,
	input  wire  [7:0] dsw1,
	input  wire        vid_cs,
	input  wire  [7:0] vid_do,
	output logic       snd_req,
	output logic [7:0] snd_no,
	output logic [7:0] vid_mode
);

	logic       cs_ram;
	logic       port_dv;
	logic [7:0] port_do;
	logic [7:0] rom0_raw;
	logic [7:0] rom0_do;
	logic [7:0] rom1_do;
	logic [7:0] ram_do;

	sys1_bus_decode u_decode (
		.CLK48M(CLK48M), .RESET(RESET), .cpu_bus(cpu_bus),
		.vid_cs(vid_cs), .vid_do(vid_do),
		.port_dv(port_dv), .port_do(port_do), .vid_mode(vid_mode),
		.rom0_do(rom0_do), .rom1_do(rom1_do), .ram_do(ram_do),
		.cs_ram(cs_ram), .cs_rom0(), .cs_rom1(),
		.cpu_din(cpu_din)
	);

	sys1_iport u_iport (
		.cpu_bus(cpu_bus),
		.inp0(inp0), .inp1(inp1), .inp2(inp2), .dsw0(dsw0), .dsw1(dsw1),
		.port_dv(port_dv), .port_do(port_do)
	);

	// Shared ROM array where download has priority over CPU fetch
	sys1_prog_rom u_prom (
		.CLK48M(CLK48M), .cpu_bus(cpu_bus), .rom_dl(rom_dl),
		.rom0_raw(rom0_raw), .rom1_do(rom1_do)
	);

	sys1_opdecrypt u_decrypt (
		.CLK48M(CLK48M), .RESET(RESET), .cpu_bus(cpu_bus), .rom_dl(rom_dl),
		.rom0_raw(rom0_raw), .rom0_do(rom0_do)
	);

	sys1_work_ram u_wram (
		.CLK48M(CLK48M), .cpu_bus(cpu_bus), .cs_ram(cs_ram), .ram_do(ram_do)
	);

	sys1_io_latch u_latch (
		.CLK48M(CLK48M), .RESET(RESET), .cpu_bus(cpu_bus),
		.snd_req(snd_req), .snd_no(snd_no), .vid_mode(vid_mode)
	);

endmodule

`default_nettype wire

// File: logic/sys1_work_ram.sv
// Read-old-data RAM; contents are undefined after power-up and untouched by reset
`timescale 1ns/1ns
`default_nettype none

module sys1_work_ram
	import sys1_bus_pkg::*, sys1_map_pkg::*;
(
	input  wire        CLK48M,
	input  cpu_bus_t   cpu_bus,
	input  wire        cs_ram,
	output logic [7:0] ram_do
);

	logic [7:0] mem [0:(2**MRAM_BITS)-1];

	always_ff @(posedge CLK48M) begin
		if (cs_ram && cpu_bus.wr) begin
			mem[cpu_bus.addr.mem[MRAM_BITS-1:0]] <= cpu_bus.dout;
		end
		ram_do <= mem[cpu_bus.addr.mem[MRAM_BITS-1:0]];
	end

endmodule

`default_nettype wire

// File: logic/sys1_io_latch.sv
// Full 8-bit port compare; snd_req is one CLK48M cycle wide whatever the CPU write length
`timescale 1ns/1ns
`default_nettype none

module sys1_io_latch
	import sys1_bus_pkg::*, sys1_map_pkg::*;
(
	input  wire        CLK48M,
	input  wire        RESET,
	input  cpu_bus_t   cpu_bus,
	output logic       snd_req,
	output logic [7:0] snd_no,
	output logic [7:0] vid_mode
);

	logic io_wr;
	logic wr_sreq;
	logic wr_vidm;

	assign io_wr   = cpu_bus.iorq && cpu_bus.wr;
	assign wr_sreq = io_wr &&
		((cpu_bus.addr.mem[7:0] == PORT_SREQ_A) || (cpu_bus.addr.mem[7:0] == PORT_SREQ_B));
	assign wr_vidm = io_wr &&
		((cpu_bus.addr.mem[7:0] == PORT_VIDM_A) || (cpu_bus.addr.mem[7:0] == PORT_VIDM_B));

	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			snd_req  <= 1'b0;
			snd_no   <= 8'h00;
			vid_mode <= 8'h00;
		end else begin
			snd_req <= wr_sreq;
			if (wr_sreq) snd_no <= cpu_bus.dout;
			if (wr_vidm) vid_mode <= cpu_bus.dout;
		end
	end

endmodule

`default_nettype wire

// File: logic/sys1_opdecrypt.sv
// Simple XOR scheme from a downloaded 16-byte key table; it does not reproduce the original tables
`timescale 1ns/1ns
`default_nettype none

module sys1_opdecrypt
	import sys1_bus_pkg::*, sys1_map_pkg::*;
(
	input  wire        CLK48M,
	input  wire        RESET,
	input  cpu_bus_t   cpu_bus,
	input  rom_dl_t    rom_dl,
	input  wire  [7:0] rom0_raw,
	output logic [7:0] rom0_do
);

	logic [7:0]          key [0:(2**KEY_BITS)-1];
	logic [KEY_BITS-1:0] idx_q;
	logic                bypass_q;
	logic                dl_key;
	logic                dl_rom;

	assign dl_key = rom_dl.en && (rom_dl.addr[24:KEY_BITS] == DL_KEY_BASE[24:KEY_BITS]);
	assign dl_rom = rom_dl.en &&
		((rom_dl.addr[24:MROM0_BITS] == DL_ROM0_BASE[24:MROM0_BITS]) ||
		(rom_dl.addr[24:MROM1_BITS] == DL_ROM1_BASE[24:MROM1_BITS]));

	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < 2**KEY_BITS; i++) begin
				key[i] <= 8'h00;
			end
			bypass_q <= 1'b0;
		end else begin
			if (dl_key) begin
				key[rom_dl.addr[KEY_BITS-1:0]] <= rom_dl.data;
			end
			// Open bus from a colliding read passes unchanged
			bypass_q <= dl_rom;
		end
	end

	// Key index travels with the ROM byte
	always_ff @(posedge CLK48M) begin
		idx_q <= {cpu_bus.m1, cpu_bus.addr.mem[12], cpu_bus.addr.mem[8], cpu_bus.addr.mem[4]};
	end

	assign rom0_do = bypass_q ? rom0_raw : (rom0_raw ^ key[idx_q]);

endmodule

`default_nettype wire

// File: logic/sys1_prog_rom.sv
// One 48 KiB array; a download write in the same cycle turns the CPU read into open bus
`timescale 1ns/1ns
`default_nettype none

module sys1_prog_rom
	import sys1_bus_pkg::*, sys1_map_pkg::*;
(
	input  wire        CLK48M,
	input  cpu_bus_t   cpu_bus,
	input  rom_dl_t    rom_dl,
	output logic [7:0] rom0_raw,
	output logic [7:0] rom1_do
);

	logic [7:0]  mem [0:(2**MROM0_BITS)+(2**MROM1_BITS)-1];
	logic [7:0]  rom_q;
	logic [15:0] rd_addr;
	logic        dl_rom0;
	logic        dl_rom1;
	logic        dl_wr;

	assign dl_rom0 = rom_dl.addr[24:MROM0_BITS] == DL_ROM0_BASE[24:MROM0_BITS];
	assign dl_rom1 = rom_dl.addr[24:MROM1_BITS] == DL_ROM1_BASE[24:MROM1_BITS];
	assign dl_wr   = rom_dl.en && (dl_rom0 || dl_rom1);

	// Encrypted bank below 8000h, plain bank above
	always_comb begin
		if (!cpu_bus.addr.mem[15]) begin
			rd_addr = {1'b0, cpu_bus.addr.mem[MROM0_BITS-1:0]};
		end else begin
			rd_addr = {2'b10, cpu_bus.addr.mem[MROM1_BITS-1:0]};
		end
	end

	always_ff @(posedge CLK48M) begin
		if (dl_wr) begin
			mem[rom_dl.addr[15:0]] <= rom_dl.data;
		end
	end

	// Download owns the array in its cycle
	always_ff @(posedge CLK48M) begin
		if (dl_wr) begin
			rom_q <= OPEN_BUS;
		end else begin
			rom_q <= mem[rd_addr];
		end
	end

	assign rom0_raw = rom_q;
	assign rom1_do  = rom_q;

endmodule

`default_nettype wire

// File: logic/sys1_iport.sv
// Partial port decode on A4..A2 and A0 only, so the input ports mirror across the I/O space
`timescale 1ns/1ns
`default_nettype none

module sys1_iport
	import sys1_bus_pkg::*, sys1_map_pkg::*;
(
	input  cpu_bus_t   cpu_bus,
	input  wire  [7:0] inp0,
	input  wire  [7:0] inp1,
	input  wire  [7:0] inp2,
	input  wire  [7:0] dsw0,
	input  wire  [7:0] dsw1,
	output logic       port_dv,
	output logic [7:0] port_do
);

	logic cs_p0;
	logic cs_p1;
	logic cs_p2;
	logic cs_sw0;
	logic cs_sw1;

	assign cs_p0  = cpu_bus.iorq && (cpu_bus.addr.io.grp == 3'b000);
	assign cs_p1  = cpu_bus.iorq && (cpu_bus.addr.io.grp == 3'b001);
	assign cs_p2  = cpu_bus.iorq && (cpu_bus.addr.io.grp == 3'b010);
	assign cs_sw0 = cpu_bus.iorq && (cpu_bus.addr.io.grp == 3'b011) && !cpu_bus.addr.io.sub;
	// Second switch bank answers at two places
	assign cs_sw1 = cpu_bus.iorq &&
		(((cpu_bus.addr.io.grp == 3'b011) && cpu_bus.addr.io.sub) ||
		(cpu_bus.addr.io.grp == 3'b100));

	assign port_dv = cs_p0 || cs_p1 || cs_p2 || cs_sw0 || cs_sw1;

	always_comb begin
		port_do = OPEN_BUS;
		if (cs_p0) port_do = inp0;
		else if (cs_p1) port_do = inp1;
		else if (cs_p2) port_do = inp2;
		else if (cs_sw0) port_do = dsw0;
		else if (cs_sw1) port_do = dsw1;
	end

endmodule

`default_nettype wire

// File: logic/sys1_bus_decode.sv
// Read sources are captured only while rd is high; memory data arrives one cycle after the selects
`timescale 1ns/1ns
`default_nettype none

module sys1_bus_decode
	import sys1_bus_pkg::*, sys1_map_pkg::*;
(
	input  wire        CLK48M,
	input  wire        RESET,
	input  cpu_bus_t   cpu_bus,
	input  wire        vid_cs,
	input  wire  [7:0] vid_do,
	input  wire        port_dv,
	input  wire  [7:0] port_do,
	input  wire  [7:0] vid_mode,
	input  wire  [7:0] rom0_do,
	input  wire  [7:0] rom1_do,
	input  wire  [7:0] ram_do,
	output logic       cs_ram,
	output logic       cs_rom0,
	output logic       cs_rom1,
	output logic [7:0] cpu_din
);

	logic       cs_vidm;
	logic       sel_dir_q;
	logic       sel_ram_q;
	logic       sel_rom0_q;
	logic       sel_rom1_q;
	logic [7:0] dir_q;

	assign cs_rom0 = cpu_bus.mreq &&
		(cpu_bus.addr.mem[15:MROM0_BITS] == MROM0_BASE[15:MROM0_BITS]);
	assign cs_rom1 = cpu_bus.mreq &&
		(cpu_bus.addr.mem[15:MROM1_BITS] == MROM1_BASE[15:MROM1_BITS]);
	assign cs_ram = cpu_bus.mreq &&
		(cpu_bus.addr.mem[15:MRAM_BITS] == MRAM_BASE[15:MRAM_BITS]);

	// Video mode reads back through its own port numbers
	assign cs_vidm = cpu_bus.iorq &&
		((cpu_bus.addr.mem[7:0] == PORT_VIDM_A) || (cpu_bus.addr.mem[7:0] == PORT_VIDM_B));

	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			sel_dir_q  <= 1'b0;
			sel_ram_q  <= 1'b0;
			sel_rom0_q <= 1'b0;
			sel_rom1_q <= 1'b0;
		end else begin
			sel_dir_q  <= cpu_bus.rd && (vid_cs || cs_vidm || port_dv);
			sel_ram_q  <= cpu_bus.rd && cs_ram;
			sel_rom0_q <= cpu_bus.rd && cs_rom0;
			sel_rom1_q <= cpu_bus.rd && cs_rom1;
		end
	end

	// Non-memory sources, video chip first
	always_ff @(posedge CLK48M) begin
		dir_q <= vid_cs ? vid_do : (cs_vidm ? vid_mode : port_do);
	end

	always_comb begin
		cpu_din = OPEN_BUS;
		if (sel_dir_q) begin
			cpu_din = dir_q;
		end else if (sel_ram_q) begin
			cpu_din = ram_do;
		end else if (sel_rom0_q) begin
			cpu_din = rom0_do;
		end else if (sel_rom1_q) begin
			cpu_din = rom1_do;
		end
	end

endmodule

`default_nettype wire

// File: logic/sys1_map_pkg.sv
// Fixed memory and port map of the main CPU board; download offsets assume the ROM image layout below
`default_nettype none

package sys1_map_pkg;

	// CPU memory regions
	localparam logic [15:0] MROM0_BASE = 16'h0000;
	localparam int          MROM0_BITS = 15;
	localparam logic [15:0] MROM1_BASE = 16'h8000;
	localparam int          MROM1_BITS = 14;
	localparam logic [15:0] MRAM_BASE  = 16'hC000;
	localparam int          MRAM_BITS  = 12;

	// Output port numbers, two mirrors each
	localparam logic [7:0] PORT_SREQ_A = 8'h14;
	localparam logic [7:0] PORT_SREQ_B = 8'h18;
	localparam logic [7:0] PORT_VIDM_A = 8'h15;
	localparam logic [7:0] PORT_VIDM_B = 8'h19;

	// Download image regions
	localparam logic [24:0] DL_ROM0_BASE = 25'h0_0000;
	localparam logic [24:0] DL_ROM1_BASE = 25'h0_8000;
	localparam logic [24:0] DL_KEY_BASE  = 25'h0_C000;
	// 16 key bytes
	localparam int          KEY_BITS     = 4;

	localparam logic [7:0] OPEN_BUS = 8'hFF;

endpackage

`default_nettype wire

// File: logic/sys1_bus_pkg.sv
// CPU bus levels are active high; the address union only re-slices the 16 bits and decodes nothing
`default_nettype none

package sys1_bus_pkg;

	// I/O port view of the CPU address, A4..A2 pick the port group
	typedef struct packed {
		logic [7:0] pad_hi;
		logic [2:0] pad_mid;
		logic [2:0] grp;
		logic       pad_a1;
		logic       sub;
	} cpu_io_addr_t;

	typedef union packed {
		logic [15:0]  mem;
		cpu_io_addr_t io;
	} cpu_addr_u;

	// One sampled CPU bus cycle
	typedef struct packed {
		cpu_addr_u  addr;
		logic [7:0] dout;
		logic       m1;
		logic       mreq;
		logic       iorq;
		logic       rd;
		logic       wr;
	} cpu_bus_t;

	// ROM image download bus, one byte per en strobe
	typedef struct packed {
		logic [24:0] addr;
		logic [7:0]  data;
		logic        en;
	} rom_dl_t;

endpackage

`default_nettype wire
